//--- verilog/udp_flash_pkg.sv
`default_nettype none

package udp_flash_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    // Length as carried in the UDP header, header bytes included
    typedef logic [15:0] udp_len_t;
    typedef logic [23:0] flash_addr_t;

    typedef enum logic [2:0] {
        st_idle,
        st_echo,
        st_read_addr,
        st_read_flash,
        st_drop
    } dispatch_state_t;

    localparam mac_addr_t BROADCAST_MAC    = 48'hffff_ffff_ffff;

    localparam udp_port_t ECHO_PORT        = 16'd1234;
    localparam udp_port_t FLASH_READ_PORT  = 16'heee0;
    localparam udp_port_t FLASH_REPLY_PORT = 16'heee1;

    // Fixed block size of every flash read reply
    localparam udp_len_t  FLASH_READ_LEN   = 16'd128;
    localparam udp_len_t  UDP_HDR_LEN      = 16'd8;

    localparam logic [7:0] FLASH_ADDR_BYTES = 8'd3;
    localparam byte_t      FLASH_CMD_READ   = 8'h03;

endpackage

`default_nettype wire

//--- verilog/spi_flash_reader.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_reader (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       read_start,
    input  logic                       read_stop,
    input  udp_flash_pkg::flash_addr_t flash_addr,
    output udp_flash_pkg::byte_t       m_tdata,
    output logic                       m_tvalid,
    input  logic                       m_tready,
    output logic                       spi_sck,
    output logic                       spi_mosi,
    input  logic                       spi_miso,
    output logic                       spi_cs
);
    import udp_flash_pkg::*;

    typedef enum logic [1:0] {
        rd_idle,
        rd_cmd,
        rd_data
    } reader_state_t;

    reader_state_t state;
    logic [31:0]   tx_shift;
    logic [6:0]    rx_shift;
    logic [4:0]    bit_cnt;
    logic          start;
    logic          sck_en;
    logic          sck_fall;

    assign start    = (state == rd_idle) && read_start;
    // SCK freezes low while an unaccepted byte is waiting
    assign sck_en   = (state != rd_idle) && (!m_tvalid || m_tready);
    assign sck_fall = sck_en && spi_sck;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= rd_idle;
            spi_cs   <= 1'b1;
            spi_sck  <= 1'b0;
            spi_mosi <= 1'b0;
            m_tvalid <= 1'b0;
            bit_cnt  <= '0;
        end
        else if (read_stop)
        begin
            state    <= rd_idle;
            spi_cs   <= 1'b1;
            spi_sck  <= 1'b0;
            m_tvalid <= 1'b0;
        end
        else
        begin
            if (m_tvalid && m_tready)
                m_tvalid <= 1'b0;
            if (sck_en)
                spi_sck <= !spi_sck;

            case (state)
                rd_idle:
                    if (start)
                    begin
                        state    <= rd_cmd;
                        spi_cs   <= 1'b0;
                        spi_mosi <= FLASH_CMD_READ[7];
                        bit_cnt  <= '0;
                    end
                rd_cmd:
                    // MOSI moves on the falling edge, 32 bits of command and address
                    if (sck_fall)
                    begin
                        spi_mosi <= tx_shift[31];
                        bit_cnt  <= bit_cnt + 5'd1;
                        if (bit_cnt == 5'd31)
                            state <= rd_data;
                    end
                rd_data:
                    if (sck_fall)
                    begin
                        if (bit_cnt == 5'd7)
                        begin
                            bit_cnt  <= '0;
                            m_tvalid <= 1'b1;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 5'd1;
                        end
                    end
                default: state <= rd_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
            tx_shift <= {FLASH_CMD_READ[6:0], flash_addr, 1'b0};
        else if (sck_fall && state == rd_cmd)
            tx_shift <= {tx_shift[30:0], 1'b0};

        // MISO sampled at the end of the high phase
        if (sck_fall && state == rd_data)
        begin
            rx_shift <= {rx_shift[5:0], spi_miso};
            if (bit_cnt == 5'd7)
                m_tdata <= {rx_shift, spi_miso};
        end
    end

endmodule

`default_nettype wire

//--- verilog/udp_reply_tx.sv
`timescale 1ns/1ps
`default_nettype none

module udp_reply_tx (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     reply_start,
    input  udp_flash_pkg::ip_addr_t  reply_ip_source,
    input  udp_flash_pkg::ip_addr_t  reply_ip_dest,
    input  udp_flash_pkg::udp_port_t reply_source_port,
    input  udp_flash_pkg::udp_port_t reply_dest_port,
    input  udp_flash_pkg::udp_len_t  reply_length,
    input  udp_flash_pkg::byte_t     reply_tdata,
    input  logic                     reply_tvalid,
    input  logic                     reply_tlast,
    output logic                     reply_tready,
    output logic                     tx_udp_hdr_valid,
    input  logic                     tx_udp_hdr_ready,
    output udp_flash_pkg::ip_addr_t  tx_ip_source_ip,
    output udp_flash_pkg::ip_addr_t  tx_ip_dest_ip,
    output udp_flash_pkg::udp_port_t tx_udp_source_port,
    output udp_flash_pkg::udp_port_t tx_udp_dest_port,
    output udp_flash_pkg::udp_len_t  tx_udp_length,
    output udp_flash_pkg::byte_t     tx_payload_tdata,
    output logic                     tx_payload_tvalid,
    input  logic                     tx_payload_tready,
    output logic                     tx_payload_tlast
);
    logic buf_free;
    logic load;

    assign buf_free = !tx_payload_tvalid || tx_payload_tready;
    // Closing byte waits until the header is out, so the next reply cannot overwrite it
    assign reply_tready = buf_free && !(reply_tlast && (tx_udp_hdr_valid || reply_start));
    assign load = reply_tvalid && reply_tready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tx_udp_hdr_valid  <= 1'b0;
            tx_payload_tvalid <= 1'b0;
        end
        else
        begin
            if (reply_start)
                tx_udp_hdr_valid <= 1'b1;
            else if (tx_udp_hdr_ready)
                tx_udp_hdr_valid <= 1'b0;

            if (load)
                tx_payload_tvalid <= 1'b1;
            else if (tx_payload_tready)
                tx_payload_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reply_start)
        begin
            tx_ip_source_ip    <= reply_ip_source;
            tx_ip_dest_ip      <= reply_ip_dest;
            tx_udp_source_port <= reply_source_port;
            tx_udp_dest_port   <= reply_dest_port;
            tx_udp_length      <= reply_length;
        end
        if (load)
        begin
            tx_payload_tdata <= reply_tdata;
            tx_payload_tlast <= reply_tlast;
        end
    end

endmodule

`default_nettype wire

//--- verilog/udp_cmd_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module udp_cmd_dispatch (
    input  logic                       clk,
    input  logic                       rst,
    input  udp_flash_pkg::mac_addr_t   local_mac,
    input  udp_flash_pkg::ip_addr_t    local_ip,
    input  logic                       rx_udp_hdr_valid,
    output logic                       rx_udp_hdr_ready,
    input  udp_flash_pkg::mac_addr_t   rx_eth_dest_mac,
    input  udp_flash_pkg::ip_addr_t    rx_ip_source_ip,
    input  udp_flash_pkg::udp_port_t   rx_udp_source_port,
    input  udp_flash_pkg::udp_port_t   rx_udp_dest_port,
    input  udp_flash_pkg::udp_len_t    rx_udp_length,
    input  udp_flash_pkg::byte_t       rx_payload_tdata,
    input  logic                       rx_payload_tvalid,
    output logic                       rx_payload_tready,
    input  logic                       rx_payload_tlast,
    output logic                       reply_start,
    output udp_flash_pkg::ip_addr_t    reply_ip_source,
    output udp_flash_pkg::ip_addr_t    reply_ip_dest,
    output udp_flash_pkg::udp_port_t   reply_source_port,
    output udp_flash_pkg::udp_port_t   reply_dest_port,
    output udp_flash_pkg::udp_len_t    reply_length,
    output udp_flash_pkg::byte_t       reply_tdata,
    output logic                       reply_tvalid,
    output logic                       reply_tlast,
    input  logic                       reply_tready,
    output logic                       read_start,
    output logic                       read_stop,
    output udp_flash_pkg::flash_addr_t flash_addr,
    input  udp_flash_pkg::byte_t       flash_tdata,
    input  logic                       flash_tvalid,
    output logic                       flash_tready
);
    import udp_flash_pkg::*;

    dispatch_state_t state;
    logic            mac_ok;
    logic            hdr_fire;
    logic            rx_fire;
    logic            flash_fire;
    logic            rx_open;
    logic [7:0]      addr_cnt;
    udp_len_t        flash_cnt;

    assign mac_ok = (rx_eth_dest_mac == local_mac) || (rx_eth_dest_mac == BROADCAST_MAC);
    assign rx_udp_hdr_ready = (state == st_idle);
    assign hdr_fire   = rx_udp_hdr_valid && rx_udp_hdr_ready;
    assign rx_fire    = rx_payload_tvalid && rx_payload_tready;
    assign flash_fire = flash_tvalid && flash_tready;

    always_comb
    begin
        rx_payload_tready = 1'b0;
        flash_tready      = 1'b0;
        reply_tvalid      = 1'b0;
        reply_tdata       = rx_payload_tdata;
        reply_tlast       = 1'b0;
        case (state)
            st_echo:
            begin
                rx_payload_tready = reply_tready;
                reply_tvalid      = rx_payload_tvalid;
                reply_tlast       = rx_payload_tlast;
            end
            st_read_addr:
                rx_payload_tready = 1'b1;
            st_read_flash:
            begin
                // Any payload beyond the address is drained meanwhile
                rx_payload_tready = rx_open;
                flash_tready      = reply_tready;
                reply_tvalid      = flash_tvalid;
                reply_tdata       = flash_tdata;
                reply_tlast       = (flash_cnt == FLASH_READ_LEN - 16'd1);
            end
            st_drop:
                rx_payload_tready = rx_open;
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state       <= st_idle;
            rx_open     <= 1'b0;
            reply_start <= 1'b0;
            read_start  <= 1'b0;
            read_stop   <= 1'b0;
            addr_cnt    <= '0;
            flash_cnt   <= '0;
        end
        else
        begin
            reply_start <= 1'b0;
            read_start  <= 1'b0;
            read_stop   <= 1'b0;

            // Payload of the current datagram not yet fully consumed
            if (hdr_fire)
                rx_open <= 1'b1;
            else if (rx_fire && rx_payload_tlast)
                rx_open <= 1'b0;

            case (state)
                st_idle:
                begin
                    addr_cnt  <= '0;
                    flash_cnt <= '0;
                    if (hdr_fire)
                    begin
                        if (mac_ok && rx_udp_dest_port == ECHO_PORT)
                        begin
                            state       <= st_echo;
                            reply_start <= 1'b1;
                        end
                        else if (mac_ok && rx_udp_dest_port == FLASH_READ_PORT)
                            state <= st_read_addr;
                        else
                            state <= st_drop;
                    end
                end
                st_echo:
                    if (rx_fire && rx_payload_tlast)
                        state <= st_idle;
                st_read_addr:
                    if (rx_fire)
                    begin
                        addr_cnt <= addr_cnt + 8'd1;
                        if (addr_cnt == FLASH_ADDR_BYTES - 8'd1)
                        begin
                            read_start  <= 1'b1;
                            reply_start <= 1'b1;
                            state       <= st_read_flash;
                        end
                        else if (rx_payload_tlast)
                            state <= st_drop;
                    end
                st_read_flash:
                    if (flash_fire)
                    begin
                        flash_cnt <= flash_cnt + 16'd1;
                        if (reply_tlast)
                        begin
                            read_stop <= 1'b1;
                            state     <= st_drop;
                        end
                    end
                st_drop:
                    if (!rx_open)
                        state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (hdr_fire)
        begin
            reply_ip_source <= local_ip;
            reply_ip_dest   <= rx_ip_source_ip;
            if (rx_udp_dest_port == FLASH_READ_PORT)
            begin
                reply_source_port <= FLASH_READ_PORT;
                reply_dest_port   <= FLASH_REPLY_PORT;
                reply_length      <= FLASH_READ_LEN + UDP_HDR_LEN;
            end
            else
            begin
                reply_source_port <= rx_udp_dest_port;
                reply_dest_port   <= rx_udp_source_port;
                reply_length      <= rx_udp_length;
            end
        end
        // Address arrives low byte first
        if (state == st_read_addr && rx_fire)
            flash_addr <= {rx_payload_tdata, flash_addr[23:8]};
    end

endmodule

`default_nettype wire

//--- verilog/udp_flash_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module udp_flash_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  udp_flash_pkg::mac_addr_t local_mac,
    input  udp_flash_pkg::ip_addr_t  local_ip,
    input  logic                     rx_udp_hdr_valid,
    output logic                     rx_udp_hdr_ready,
    input  udp_flash_pkg::mac_addr_t rx_eth_dest_mac,
    input  udp_flash_pkg::ip_addr_t  rx_ip_source_ip,
    input  udp_flash_pkg::udp_port_t rx_udp_source_port,
    input  udp_flash_pkg::udp_port_t rx_udp_dest_port,
    input  udp_flash_pkg::udp_len_t  rx_udp_length,
    input  udp_flash_pkg::byte_t     rx_payload_tdata,
    input  logic                     rx_payload_tvalid,
    output logic                     rx_payload_tready,
    input  logic                     rx_payload_tlast,
    output logic                     tx_udp_hdr_valid,
    input  logic                     tx_udp_hdr_ready,
    output udp_flash_pkg::ip_addr_t  tx_ip_source_ip,
    output udp_flash_pkg::ip_addr_t  tx_ip_dest_ip,
    output udp_flash_pkg::udp_port_t tx_udp_source_port,
    output udp_flash_pkg::udp_port_t tx_udp_dest_port,
    output udp_flash_pkg::udp_len_t  tx_udp_length,
    output udp_flash_pkg::byte_t     tx_payload_tdata,
    output logic                     tx_payload_tvalid,
    input  logic                     tx_payload_tready,
    output logic                     tx_payload_tlast,
    output logic                     spi_sck,
    output logic                     spi_mosi,
    input  logic                     spi_miso,
    output logic                     spi_cs
);
    import udp_flash_pkg::*;

    // Dispatcher to reply stage
    logic        reply_start;
    ip_addr_t    reply_ip_source;
    ip_addr_t    reply_ip_dest;
    udp_port_t   reply_source_port;
    udp_port_t   reply_dest_port;
    udp_len_t    reply_length;
    byte_t       reply_tdata;
    logic        reply_tvalid;
    logic        reply_tlast;
    logic        reply_tready;

    // Dispatcher to flash reader
    logic        read_start;
    logic        read_stop;
    flash_addr_t flash_addr;
    byte_t       flash_tdata;
    logic        flash_tvalid;
    logic        flash_tready;

    udp_cmd_dispatch i_udp_cmd_dispatch (.*);

    spi_flash_reader i_spi_flash_reader (
        .m_tdata  (flash_tdata),
        .m_tvalid (flash_tvalid),
        .m_tready (flash_tready),
        .*
    );

    udp_reply_tx i_udp_reply_tx (.*);

endmodule

`default_nettype wire

//--- sim/spi_flash_model.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_model (
    input  logic spi_cs,
    input  logic spi_sck,
    input  logic spi_mosi,
    output logic spi_miso
);
    logic [31:0] cmd_addr;
    logic [5:0]  in_cnt;
    logic [15:0] out_cnt;
    logic [7:0]  data_byte;

    // Command and address, sampled on the rising edge
    always @(posedge spi_sck or posedge spi_cs)
    begin
        if (spi_cs)
        begin
            in_cnt <= '0;
        end
        else if (in_cnt < 6'd32)
        begin
            cmd_addr <= {cmd_addr[30:0], spi_mosi};
            in_cnt   <= in_cnt + 6'd1;
        end
    end

    // Read data, low address byte XOR 0xa5, MSB first on the falling edge
    always @(negedge spi_sck or posedge spi_cs)
    begin
        if (spi_cs)
        begin
            out_cnt  <= '0;
            spi_miso <= 1'b0;
        end
        else if (in_cnt == 6'd32 && cmd_addr[31:24] == 8'h03)
        begin
            data_byte = (cmd_addr[7:0] + 8'(out_cnt >> 3)) ^ 8'ha5;
            spi_miso <= data_byte[3'd7 - out_cnt[2:0]];
            out_cnt  <= out_cnt + 16'd1;
        end
    end

endmodule

`default_nettype wire

//--- sim/udp_flash_ctrl_chk.sv
`timescale 1ns/1ps
`default_nettype none

module udp_flash_ctrl_chk (
    input logic                     clk,
    input logic                     rst,
    input logic                     tx_udp_hdr_valid,
    input logic                     tx_udp_hdr_ready,
    input udp_flash_pkg::ip_addr_t  tx_ip_source_ip,
    input udp_flash_pkg::ip_addr_t  tx_ip_dest_ip,
    input udp_flash_pkg::udp_port_t tx_udp_source_port,
    input udp_flash_pkg::udp_port_t tx_udp_dest_port,
    input udp_flash_pkg::udp_len_t  tx_udp_length,
    input udp_flash_pkg::byte_t     tx_payload_tdata,
    input logic                     tx_payload_tvalid,
    input logic                     tx_payload_tready,
    input logic                     tx_payload_tlast,
    input logic                     spi_sck,
    input logic                     spi_cs
);

    int unsigned fail_count = 0;

    a_payload_hold: assert property (
        @(posedge clk) disable iff (rst)
        tx_payload_tvalid && !tx_payload_tready |=>
            tx_payload_tvalid && $stable(tx_payload_tdata) && $stable(tx_payload_tlast))
    else
    begin
        fail_count++;
        $error("tx payload byte changed or vanished while stalled");
    end

    a_header_hold: assert property (
        @(posedge clk) disable iff (rst)
        tx_udp_hdr_valid && !tx_udp_hdr_ready |=>
            tx_udp_hdr_valid && $stable({tx_ip_source_ip, tx_ip_dest_ip,
            tx_udp_source_port, tx_udp_dest_port, tx_udp_length}))
    else
    begin
        fail_count++;
        $error("tx header changed or vanished while stalled");
    end

    // Mode 0 idles with the clock low
    a_sck_idle: assert property (
        @(posedge clk) disable iff (rst)
        spi_cs |-> !spi_sck)
    else
    begin
        fail_count++;
        $error("spi_sck high while spi_cs is deasserted");
    end

endmodule

bind udp_flash_ctrl udp_flash_ctrl_chk i_udp_flash_ctrl_chk (.*);

`default_nettype wire

//--- sim/tb_udp_flash_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_udp_flash_ctrl;
    import udp_flash_pkg::*;

    localparam int         WAIT_LIMIT  = 2000;
    localparam int         NUM_ROWS    = 10;
    localparam logic [1:0] MAC_LOCAL   = 2'd0;
    localparam logic [1:0] MAC_BCAST   = 2'd1;
    localparam logic [1:0] MAC_FOREIGN = 2'd2;
    localparam mac_addr_t  LOCAL_MAC   = 48'h02_00_00_00_00_01;
    localparam ip_addr_t   LOCAL_IP    = 32'hc0a8_0102;

    // One datagram per row
    // arg holds the payload length or the flash address
    typedef struct packed {
        logic [1:0]  mac_sel;
        udp_port_t   dest_port;
        ip_addr_t    src_ip;
        udp_port_t   src_port;
        logic [23:0] arg;
        logic        random_ready;
    } row_t;

    row_t        rows [NUM_ROWS];
    logic        clk = 1'b0;
    logic        rst;
    mac_addr_t   local_mac;
    ip_addr_t    local_ip;
    logic        rx_udp_hdr_valid;
    logic        rx_udp_hdr_ready;
    mac_addr_t   rx_eth_dest_mac;
    ip_addr_t    rx_ip_source_ip;
    udp_port_t   rx_udp_source_port;
    udp_port_t   rx_udp_dest_port;
    udp_len_t    rx_udp_length;
    byte_t       rx_payload_tdata;
    logic        rx_payload_tvalid;
    logic        rx_payload_tready;
    logic        rx_payload_tlast;
    logic        tx_udp_hdr_valid;
    logic        tx_udp_hdr_ready;
    ip_addr_t    tx_ip_source_ip;
    ip_addr_t    tx_ip_dest_ip;
    udp_port_t   tx_udp_source_port;
    udp_port_t   tx_udp_dest_port;
    udp_len_t    tx_udp_length;
    byte_t       tx_payload_tdata;
    logic        tx_payload_tvalid;
    logic        tx_payload_tready;
    logic        tx_payload_tlast;
    logic        spi_sck;
    logic        spi_mosi;
    logic        spi_miso;
    logic        spi_cs;
    logic        random_ready = 1'b0;
    logic        quiet_window = 1'b0;
    logic [31:0] rnd;

    udp_flash_ctrl i_udp_flash_ctrl (.*);

    spi_flash_model i_spi_flash_model (.*);

    always #4 clk = !clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp)
            abort_run($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic compare_port(input string name, input udp_port_t exp, input udp_port_t act);
        if (act !== exp)
            abort_run($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic compare_ip(input string name, input ip_addr_t exp, input ip_addr_t act);
        if (act !== exp)
            abort_run($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic compare_len(input string name, input udp_len_t exp, input udp_len_t act);
        if (act !== exp)
            abort_run($sformatf("Error %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("Error %s: expected %b, actual %b", name, exp, act));
    endtask

    function automatic mac_addr_t mac_for(input logic [1:0] sel);
        if (sel == MAC_LOCAL)
            return LOCAL_MAC;
        else if (sel == MAC_BCAST)
            return 48'hffff_ffff_ffff;
        else
            return 48'h02_00_00_00_00_99;
    endfunction

    task automatic send_datagram(input row_t r, input byte_t data[$], input logic mark_quiet);
        int   tmo;
        logic done;
        @(posedge clk);
        #1;
        rx_udp_hdr_valid   = 1'b1;
        rx_eth_dest_mac    = mac_for(r.mac_sel);
        rx_ip_source_ip    = r.src_ip;
        rx_udp_source_port = r.src_port;
        rx_udp_dest_port   = r.dest_port;
        rx_udp_length      = udp_len_t'(data.size() + 8);
        tmo  = 0;
        done = 1'b0;
        while (!done)
        begin
            @(posedge clk);
            done = rx_udp_hdr_ready;
            tmo++;
            if (!done && tmo > WAIT_LIMIT)
                abort_run("Timeout: the DUT never accepted the datagram header");
        end
        #1;
        rx_udp_hdr_valid = 1'b0;
        quiet_window     = mark_quiet;
        for (int k = 0; k < data.size(); k++)
        begin
            rx_payload_tdata  = data[k];
            rx_payload_tvalid = 1'b1;
            rx_payload_tlast  = (k == data.size() - 1);
            tmo  = 0;
            done = 1'b0;
            while (!done)
            begin
                @(posedge clk);
                done = rx_payload_tready;
                tmo++;
                if (!done && tmo > WAIT_LIMIT)
                    abort_run("Timeout: the DUT stopped consuming payload bytes");
            end
            #1;
        end
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast  = 1'b0;
    endtask

    task automatic take_header(input string name, input ip_addr_t dest_ip,
                               input udp_port_t src_port, input udp_port_t dst_port,
                               input udp_len_t len);
        int   tmo;
        logic done;
        tmo  = 0;
        done = 1'b0;
        while (!done)
        begin
            @(posedge clk);
            done = tx_udp_hdr_valid && tx_udp_hdr_ready;
            tmo++;
            if (!done && tmo > WAIT_LIMIT)
                abort_run("Timeout: no reply header was sent by the DUT");
        end
        compare_ip({name, " source ip"}, LOCAL_IP, tx_ip_source_ip);
        compare_ip({name, " dest ip"}, dest_ip, tx_ip_dest_ip);
        compare_port({name, " source port"}, src_port, tx_udp_source_port);
        compare_port({name, " dest port"}, dst_port, tx_udp_dest_port);
        compare_len({name, " length"}, len, tx_udp_length);
    endtask

    task automatic take_payload(input string name, input byte_t exp[$]);
        int   tmo;
        logic done;
        for (int k = 0; k < exp.size(); k++)
        begin
            tmo  = 0;
            done = 1'b0;
            while (!done)
            begin
                @(posedge clk);
                done = tx_payload_tvalid && tx_payload_tready;
                tmo++;
                if (!done && tmo > WAIT_LIMIT)
                    abort_run("Timeout: the reply payload stalled before its last byte");
            end
            compare_byte($sformatf("%s byte %0d", name, k), exp[k], tx_payload_tdata);
            compare_flag($sformatf("%s tlast %0d", name, k), k == exp.size() - 1,
                         tx_payload_tlast);
        end
    endtask

    task automatic wait_idle(input string name);
        int tmo;
        tmo = 0;
        while (!rx_udp_hdr_ready)
        begin
            @(posedge clk);
            tmo++;
            if (tmo > WAIT_LIMIT)
                abort_run({"Timeout: the DUT did not return to idle after ", name});
        end
    endtask

    task automatic run_row(input int idx);
        row_t      r;
        byte_t     payload[$];
        byte_t     expect_q[$];
        byte_t     lo;
        string     name;
        logic      is_flash;
        logic      replies;
        udp_port_t exp_src;
        udp_port_t exp_dst;
        udp_len_t  exp_len;
        r        = rows[idx];
        name     = $sformatf("row %0d", idx);
        is_flash = (r.dest_port == 16'heee0);
        replies  = (r.mac_sel != MAC_FOREIGN) && (is_flash || r.dest_port == 16'd1234);
        if (is_flash)
        begin
            payload = '{r.arg[7:0], r.arg[15:8], r.arg[23:16]};
            for (int k = 0; k < 128; k++)
            begin
                lo = r.arg[7:0] + 8'(k);
                expect_q.push_back(lo ^ 8'ha5);
            end
            exp_src = 16'heee0;
            exp_dst = 16'heee1;
            exp_len = 16'd136;
        end
        else
        begin
            for (int k = 0; k < int'(r.arg); k++)
                payload.push_back(8'(k * 37 + idx * 11 + 3));
            expect_q = payload;
            exp_src  = r.dest_port;
            exp_dst  = r.src_port;
            exp_len  = udp_len_t'(payload.size() + 8);
        end
        random_ready = r.random_ready;
        if (replies)
        begin
            fork
                send_datagram(r, payload, 1'b0);
                take_header(name, r.src_ip, exp_src, exp_dst, exp_len);
                take_payload(name, expect_q);
            join
        end
        else
        begin
            send_datagram(r, payload, 1'b1);
            wait_idle(name);
        end
        random_ready = 1'b0;
    endtask

    // No reply header may show up for a dropped datagram
    always @(posedge clk)
    begin
        if (quiet_window && tx_udp_hdr_valid)
            abort_run("A reply header was sent for a datagram that should be dropped");
    end

    // Protocol assertions of the bound checker
    always @(posedge clk)
    begin
        if (i_udp_flash_ctrl.i_udp_flash_ctrl_chk.fail_count != 0)
            abort_run("A protocol assertion on the transmit or SPI side failed");
    end

    // Transmit ready signals randomized only in back-pressure rows
    initial
    begin
        void'($urandom(30));
        tx_payload_tready = 1'b1;
        tx_udp_hdr_ready  = 1'b1;
        forever
        begin
            @(posedge clk);
            #1;
            rnd = $urandom;
            tx_payload_tready = random_ready ? rnd[0] : 1'b1;
            tx_udp_hdr_ready  = random_ready ? rnd[1] : 1'b1;
        end
    end

    initial
    begin
        rst                = 1'b1;
        local_mac          = LOCAL_MAC;
        local_ip           = LOCAL_IP;
        rx_udp_hdr_valid   = 1'b0;
        rx_eth_dest_mac    = '0;
        rx_ip_source_ip    = '0;
        rx_udp_source_port = '0;
        rx_udp_dest_port   = '0;
        rx_udp_length      = '0;
        rx_payload_tdata   = '0;
        rx_payload_tvalid  = 1'b0;
        rx_payload_tlast   = 1'b0;

        rows[0] = '{MAC_LOCAL,   16'd1234,  32'h0a00_0002, 16'd5000,  24'd16,       1'b0};
        rows[1] = '{MAC_BCAST,   16'd1234,  32'h0a00_0003, 16'd5001,  24'd5,        1'b0};
        rows[2] = '{MAC_FOREIGN, 16'd1234,  32'h0a00_0004, 16'd5002,  24'd10,       1'b0};
        rows[3] = '{MAC_LOCAL,   16'd80,    32'h0a00_0005, 16'd5003,  24'd7,        1'b0};
        rows[4] = '{MAC_LOCAL,   16'd1234,  32'h0a00_0006, 16'd5004,  24'd1,        1'b0};
        rows[5] = '{MAC_LOCAL,   16'heee0,  32'h0a00_0007, 16'd6000,  24'h0012f0,   1'b0};
        rows[6] = '{MAC_FOREIGN, 16'heee0,  32'h0a00_0008, 16'd6001,  24'h000100,   1'b0};
        rows[7] = '{MAC_LOCAL,   16'd1234,  32'h0a00_0009, 16'd5005,  24'd24,       1'b1};
        rows[8] = '{MAC_LOCAL,   16'heee0,  32'h0a00_000a, 16'd6002,  24'h1234c3,   1'b1};
        rows[9] = '{MAC_BCAST,   16'heee0,  32'h0a00_000b, 16'd6003,  24'habcdef,   1'b0};

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        compare_flag("reset tx_udp_hdr_valid", 1'b0, tx_udp_hdr_valid);
        compare_flag("reset tx_payload_tvalid", 1'b0, tx_payload_tvalid);
        compare_flag("reset spi_cs", 1'b1, spi_cs);
        compare_flag("reset spi_sck", 1'b0, spi_sck);
        compare_flag("reset rx_udp_hdr_ready", 1'b1, rx_udp_hdr_ready);

        for (int i = 0; i < NUM_ROWS; i++)
            run_row(i);

        @(posedge clk);
        if (i_udp_flash_ctrl.i_udp_flash_ctrl_chk.fail_count != 0)
            abort_run("A protocol assertion on the transmit or SPI side failed");
        else
        begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/udp_flash_pkg.sv
verilog/spi_flash_reader.sv
verilog/udp_reply_tx.sv
verilog/udp_cmd_dispatch.sv
verilog/udp_flash_ctrl.sv
sim/spi_flash_model.sv
sim/udp_flash_ctrl_chk.sv
sim/tb_udp_flash_ctrl.sv

//--- Bender.yml
package:
  name: udp_flash_ctrl

sources:
  - files:
      - verilog/udp_flash_pkg.sv
      - verilog/spi_flash_reader.sv
      - verilog/udp_reply_tx.sv
      - verilog/udp_cmd_dispatch.sv
      - verilog/udp_flash_ctrl.sv
  - target: simulation
    files:
      - sim/spi_flash_model.sv
      - sim/udp_flash_ctrl_chk.sv
      - sim/tb_udp_flash_ctrl.sv
